/* hw/exu_pkg.sv */
`default_nettype none

package exu_pkg;

    typedef logic [5:0] inst_num_t;  // Decoded instruction number.

    localparam inst_num_t inst_lui    = 6'd0;
    localparam inst_num_t inst_auipc  = 6'd1;
    localparam inst_num_t inst_jal    = 6'd2;
    localparam inst_num_t inst_jalr   = 6'd3;
    localparam inst_num_t inst_beq    = 6'd4;
    localparam inst_num_t inst_bne    = 6'd5;
    localparam inst_num_t inst_blt    = 6'd6;
    localparam inst_num_t inst_bge    = 6'd7;
    localparam inst_num_t inst_bltu   = 6'd8;
    localparam inst_num_t inst_bgeu   = 6'd9;
    localparam inst_num_t inst_lw     = 6'd10;
    localparam inst_num_t inst_lbu    = 6'd11;
    localparam inst_num_t inst_sb     = 6'd12;
    localparam inst_num_t inst_sh     = 6'd13;
    localparam inst_num_t inst_sw     = 6'd14;
    localparam inst_num_t inst_addi   = 6'd15;
    localparam inst_num_t inst_sltiu  = 6'd16;
    localparam inst_num_t inst_xori   = 6'd17;
    localparam inst_num_t inst_andi   = 6'd18;
    localparam inst_num_t inst_slli   = 6'd19;
    localparam inst_num_t inst_srli   = 6'd20;
    localparam inst_num_t inst_srai   = 6'd21;
    localparam inst_num_t inst_add    = 6'd22;
    localparam inst_num_t inst_sub    = 6'd23;
    localparam inst_num_t inst_sll    = 6'd24;
    localparam inst_num_t inst_slt    = 6'd25;
    localparam inst_num_t inst_sltu   = 6'd26;
    localparam inst_num_t inst_xor    = 6'd27;
    localparam inst_num_t inst_or     = 6'd28;
    localparam inst_num_t inst_and    = 6'd29;
    localparam inst_num_t inst_ebreak = 6'd30;  // Everything above this is unknown.

    typedef enum logic {
        in_idle,
        in_ack_high
    } in_state_t;

    typedef enum logic [1:0] {
        out_idle,
        out_req_high,
        out_wait_ack_low
    } out_state_t;

endpackage

`default_nettype wire

/* hw/exu_op_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface exu_op_if #(
    parameter int xlen = 32
) ();

    import exu_pkg::*;

    logic              valid;
    logic              ready;
    inst_num_t         inst_num;
    logic [xlen-1:0]   imm;       // Already sign-extended.
    logic [xlen-1:0]   pc;
    logic [xlen-1:0]   src1;
    logic [xlen-1:0]   src2;

    modport src (
        output valid, inst_num, imm, pc, src1, src2,
        input  ready
    );

    modport dst (
        input  valid,
        output ready
    );

    // Combinational blocks only look at the payload.
    modport mon (
        input inst_num, imm, pc, src1, src2
    );

endinterface

`default_nettype wire

/* hw/exu_in.sv */
`timescale 1ns/100ps
`default_nettype none

module exu_in #(
    parameter int xlen = 32
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_req,
    output logic                in_ack,
    input  exu_pkg::inst_num_t  inst_num,
    input  logic [xlen-1:0]     imm,
    input  logic [xlen-1:0]     pc,
    input  logic [xlen-1:0]     src1,
    input  logic [xlen-1:0]     src2,
    exu_op_if.src               op
);

    import exu_pkg::*;

    in_state_t state;
    logic      capture;

    // Accept only with in_ack low and the buffer free.
    assign capture = (state == in_idle) && in_req && !op.valid;
    assign in_ack  = (state == in_ack_high);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= in_idle;
            op.valid <= 1'b0;
        end else begin
            case (state)
                in_idle: begin
                    if (capture) begin
                        state <= in_ack_high;
                    end
                end
                in_ack_high: begin
                    if (!in_req) begin
                        state <= in_idle;  // Source has dropped its request.
                    end
                end
                default: begin
                    state <= in_idle;
                end
            endcase
            if (capture) begin
                op.valid <= 1'b1;
            end else if (op.valid && op.ready) begin
                op.valid <= 1'b0;  // Output side took the buffer.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            op.inst_num <= inst_num;
            op.imm      <= imm;
            op.pc       <= pc;
            op.src1     <= src1;
            op.src2     <= src2;
        end
    end

endmodule

`default_nettype wire

/* hw/exu_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module exu_alu #(
    parameter int xlen = 32
) (
    exu_op_if.mon           op,
    output logic [xlen-1:0] rd_value,
    output logic            rd_wen,
    output logic            cond
);

    import exu_pkg::*;

    localparam int shw = $clog2(xlen);

    logic [xlen-1:0] opb;
    logic [shw-1:0]  shamt;
    logic            is_imm_op;
    logic            eq;
    logic            lt_s;
    logic            lt_u;

    assign is_imm_op = (op.inst_num >= inst_addi) && (op.inst_num <= inst_srai);
    assign opb       = is_imm_op ? op.imm : op.src2;
    assign shamt     = opb[shw-1:0];  // Only the low bits count for shifts.
    assign eq        = (op.src1 == opb);
    assign lt_s      = ($signed(op.src1) < $signed(opb));
    assign lt_u      = (op.src1 < opb);

    always_comb begin
        rd_value = '0;
        rd_wen   = 1'b0;
        cond     = 1'b0;
        case (op.inst_num)
            inst_lui: begin
                rd_value = op.imm;
                rd_wen   = 1'b1;
            end
            inst_auipc: begin
                rd_value = op.pc + op.imm;
                rd_wen   = 1'b1;
            end
            inst_jal, inst_jalr: begin
                rd_value = op.pc + xlen'(4);  // Link address.
                rd_wen   = 1'b1;
            end
            inst_beq:  cond = eq;
            inst_bne:  cond = !eq;
            inst_blt:  cond = lt_s;
            inst_bge:  cond = !lt_s;
            inst_bltu: cond = lt_u;
            inst_bgeu: cond = !lt_u;
            inst_lw, inst_lbu, inst_sb, inst_sh, inst_sw: begin
                rd_value = op.src1 + op.imm;  // Address for the memory stage.
            end
            inst_addi, inst_add: begin
                rd_value = op.src1 + opb;
                rd_wen   = 1'b1;
            end
            inst_sub: begin
                rd_value = op.src1 - opb;
                rd_wen   = 1'b1;
            end
            inst_sltiu, inst_sltu: begin
                rd_value = {{(xlen-1){1'b0}}, lt_u};
                rd_wen   = 1'b1;
            end
            inst_slt: begin
                rd_value = {{(xlen-1){1'b0}}, lt_s};
                rd_wen   = 1'b1;
            end
            inst_xori, inst_xor: begin
                rd_value = op.src1 ^ opb;
                rd_wen   = 1'b1;
            end
            inst_or: begin
                rd_value = op.src1 | opb;
                rd_wen   = 1'b1;
            end
            inst_andi, inst_and: begin
                rd_value = op.src1 & opb;
                rd_wen   = 1'b1;
            end
            inst_slli, inst_sll: begin
                rd_value = op.src1 << shamt;
                rd_wen   = 1'b1;
            end
            inst_srli: begin
                rd_value = op.src1 >> shamt;
                rd_wen   = 1'b1;
            end
            inst_srai: begin
                rd_value = $unsigned($signed(op.src1) >>> shamt);
                rd_wen   = 1'b1;
            end
            default: begin
                rd_value = '0;  // ebreak and unknown numbers write nothing.
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/exu_pc.sv */
`timescale 1ns/100ps
`default_nettype none

module exu_pc #(
    parameter int xlen = 32
) (
    exu_op_if.mon           op,
    input  logic            cond,
    output logic [xlen-1:0] next_pc,
    output logic            halt
);

    import exu_pkg::*;

    logic [xlen-1:0] adder_a;
    logic [xlen-1:0] adder_b;
    logic [xlen-1:0] adder_s;

    always_comb begin
        adder_a = op.pc;
        adder_b = xlen'(4);
        halt    = 1'b0;
        case (op.inst_num)
            inst_jal: begin
                adder_b = op.imm;
            end
            inst_jalr: begin
                adder_a = op.src1;
                adder_b = op.imm;
            end
            inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu: begin
                adder_b = cond ? op.imm : xlen'(4);
            end
            inst_lui, inst_auipc, inst_lw, inst_lbu, inst_sb, inst_sh, inst_sw,
            inst_addi, inst_sltiu, inst_xori, inst_andi, inst_slli, inst_srli,
            inst_srai, inst_add, inst_sub, inst_sll, inst_slt, inst_sltu,
            inst_xor, inst_or, inst_and: begin
                adder_b = xlen'(4);
            end
            default: begin
                adder_b = '0;  // ebreak or unknown, so pc stays put.
                halt    = 1'b1;
            end
        endcase
    end

    assign adder_s = adder_a + adder_b;

    // jalr targets always have bit 0 cleared.
    assign next_pc = (op.inst_num == inst_jalr) ? {adder_s[xlen-1:1], 1'b0} : adder_s;

endmodule

`default_nettype wire

/* hw/exu_out.sv */
`timescale 1ns/100ps
`default_nettype none

module exu_out #(
    parameter int xlen = 32
) (
    input  logic            clk,
    input  logic            reset,
    exu_op_if.dst           op,
    input  logic [xlen-1:0] rd_value_in,
    input  logic [xlen-1:0] next_pc_in,
    input  logic            rd_wen_in,
    input  logic            halt_in,
    output logic            out_req,
    input  logic            out_ack,
    output logic [xlen-1:0] rd_value,
    output logic [xlen-1:0] next_pc,
    output logic            rd_wen,
    output logic            halt
);

    import exu_pkg::*;

    out_state_t state;
    logic       take;

    assign op.ready = (state == out_idle);
    assign take     = op.valid && op.ready;
    assign out_req  = (state == out_req_high);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= out_idle;
        end else begin
            case (state)
                out_idle: begin
                    if (take) begin
                        state <= out_req_high;
                    end
                end
                out_req_high: begin
                    if (out_ack) begin
                        state <= out_wait_ack_low;  // Sink has the result.
                    end
                end
                out_wait_ack_low: begin
                    if (!out_ack) begin
                        state <= out_idle;
                    end
                end
                default: begin
                    state <= out_idle;
                end
            endcase
        end
    end

    // Results hold steady until the next transfer.
    always_ff @(posedge clk) begin
        if (take) begin
            rd_value <= rd_value_in;
            next_pc  <= next_pc_in;
            rd_wen   <= rd_wen_in;
            halt     <= halt_in;
        end
    end

endmodule

`default_nettype wire

/* hw/exu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module exu_top #(
    parameter int xlen = 32
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_req,
    output logic                in_ack,
    input  exu_pkg::inst_num_t  inst_num,
    input  logic [xlen-1:0]     imm,
    input  logic [xlen-1:0]     pc,
    input  logic [xlen-1:0]     src1,
    input  logic [xlen-1:0]     src2,
    output logic                out_req,
    input  logic                out_ack,
    output logic [xlen-1:0]     rd_value,
    output logic                rd_wen,
    output logic [xlen-1:0]     next_pc,
    output logic                halt
);

    logic [xlen-1:0] alu_rd_value;
    logic            alu_rd_wen;
    logic            alu_cond;
    logic [xlen-1:0] pc_next_pc;
    logic            pc_halt;

    exu_op_if #(.xlen(xlen)) op_if ();

    exu_in #(.xlen(xlen)) u_in (
        .clk      (clk),
        .reset    (reset),
        .in_req   (in_req),
        .in_ack   (in_ack),
        .inst_num (inst_num),
        .imm      (imm),
        .pc       (pc),
        .src1     (src1),
        .src2     (src2),
        .op       (op_if.src)
    );

    exu_alu #(.xlen(xlen)) u_alu (
        .op       (op_if.mon),
        .rd_value (alu_rd_value),
        .rd_wen   (alu_rd_wen),
        .cond     (alu_cond)
    );

    exu_pc #(.xlen(xlen)) u_pc (
        .op      (op_if.mon),
        .cond    (alu_cond),
        .next_pc (pc_next_pc),
        .halt    (pc_halt)
    );

    exu_out #(.xlen(xlen)) u_out (
        .clk         (clk),
        .reset       (reset),
        .op          (op_if.dst),
        .rd_value_in (alu_rd_value),
        .next_pc_in  (pc_next_pc),
        .rd_wen_in   (alu_rd_wen),
        .halt_in     (pc_halt),
        .out_req     (out_req),
        .out_ack     (out_ack),
        .rd_value    (rd_value),
        .next_pc     (next_pc),
        .rd_wen      (rd_wen),
        .halt        (halt)
    );

endmodule

`default_nettype wire

/* testbench/exu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module exu_tb;

    import exu_pkg::*;

    localparam int n_alu    = 200;
    localparam int n_branch = 100;
    localparam int n_jump   = 80;
    localparam int n_mem    = 80;
    localparam int n_mixed  = 200;
    localparam int total_ops = n_alu + n_branch + n_jump + n_mem + n_mixed;

    typedef struct packed {
        inst_num_t   inst;
        logic [31:0] imm;
        logic [31:0] pc;
        logic [31:0] src1;
        logic [31:0] src2;
    } op_t;

    typedef struct packed {
        inst_num_t   inst;
        logic [31:0] rd_value;
        logic        rd_wen;
        logic [31:0] next_pc;
        logic        halt;
        logic        check_rd;  // rd_value has a defined meaning for this instruction.
    } result_t;

    logic        clk;
    logic        reset;
    logic        in_req;
    logic        in_ack;
    inst_num_t   inst_num;
    logic [31:0] imm;
    logic [31:0] pc;
    logic [31:0] src1;
    logic [31:0] src2;
    logic        out_req;
    logic        out_ack;
    logic [31:0] rd_value;
    logic        rd_wen;
    logic [31:0] next_pc;
    logic        halt;

    logic [31:0] lcg_state = 32'd20538;
    result_t     exp_q[$];
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic        req_at_edge = 1'b0;
    logic        ack_before = 1'b0;

    exu_top #(.xlen(32)) uut (
        .clk      (clk),
        .reset    (reset),
        .in_req   (in_req),
        .in_ack   (in_ack),
        .inst_num (inst_num),
        .imm      (imm),
        .pc       (pc),
        .src1     (src1),
        .src2     (src2),
        .out_req  (out_req),
        .out_ack  (out_ack),
        .rd_value (rd_value),
        .rd_wen   (rd_wen),
        .next_pc  (next_pc),
        .halt     (halt)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi[31:16], lo[31:16]};  // Upper halves only, the low LCG bits cycle fast.
    endfunction

    function automatic int rand_below(int n);
        logic [31:0] r;
        r = next_rand();
        return int'(r >> 16) % n;
    endfunction

    function automatic logic branch_taken(inst_num_t inst, logic [31:0] a, logic [31:0] b);
        case (inst)
            inst_beq:  return a == b;
            inst_bne:  return a != b;
            inst_blt:  return $signed(a) < $signed(b);
            inst_bge:  return $signed(a) >= $signed(b);
            inst_bltu: return a < b;
            inst_bgeu: return a >= b;
            default:   return 1'b0;
        endcase
    endfunction

    function automatic result_t model(op_t o);
        result_t     r;
        logic [31:0] b;
        b = o.src2;
        case (o.inst)
            inst_addi, inst_sltiu, inst_xori, inst_andi, inst_slli, inst_srli, inst_srai:
                b = o.imm;
            default: b = o.src2;
        endcase
        r.inst     = o.inst;
        r.rd_value = 32'd0;
        r.rd_wen   = 1'b1;
        r.next_pc  = o.pc + 32'd4;
        r.halt     = 1'b0;
        r.check_rd = 1'b1;
        case (o.inst)
            inst_lui:   r.rd_value = o.imm;
            inst_auipc: r.rd_value = o.pc + o.imm;
            inst_jal: begin
                r.rd_value = o.pc + 32'd4;
                r.next_pc  = o.pc + o.imm;
            end
            inst_jalr: begin
                r.rd_value = o.pc + 32'd4;
                r.next_pc  = (o.src1 + o.imm) & ~32'd1;
            end
            inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu: begin
                r.rd_wen   = 1'b0;
                r.check_rd = 1'b0;
                if (branch_taken(o.inst, o.src1, o.src2)) begin
                    r.next_pc = o.pc + o.imm;
                end
            end
            inst_lw, inst_lbu, inst_sb, inst_sh, inst_sw: begin
                r.rd_wen   = 1'b0;
                r.rd_value = o.src1 + o.imm;  // Effective address.
            end
            inst_addi, inst_add:   r.rd_value = o.src1 + b;
            inst_sub:              r.rd_value = o.src1 - b;
            inst_sltiu, inst_sltu: r.rd_value = (o.src1 < b) ? 32'd1 : 32'd0;
            inst_slt:  r.rd_value = ($signed(o.src1) < $signed(b)) ? 32'd1 : 32'd0;
            inst_xori, inst_xor:   r.rd_value = o.src1 ^ b;
            inst_or:               r.rd_value = o.src1 | b;
            inst_andi, inst_and:   r.rd_value = o.src1 & b;
            inst_slli, inst_sll:   r.rd_value = o.src1 << b[4:0];
            inst_srli:             r.rd_value = o.src1 >> b[4:0];
            inst_srai:             r.rd_value = $signed(o.src1) >>> b[4:0];
            default: begin
                r.rd_wen   = 1'b0;
                r.next_pc  = o.pc;
                r.halt     = 1'b1;
                r.check_rd = 1'b0;
            end
        endcase
        return r;
    endfunction

    // Kinds: 0 ALU, 1 branch, 2 lui/auipc/jal/jalr, 3 memory and halting, 4 anything.
    function automatic op_t make_op(int kind);
        op_t         o;
        logic [31:0] w;
        int          k;
        case (kind)
            0: o.inst = inst_addi + 6'(rand_below(15));
            1: o.inst = inst_beq + 6'(rand_below(6));
            2: o.inst = 6'(rand_below(4));
            3: begin
                k = rand_below(4);
                if (k < 2) begin
                    o.inst = inst_lw + 6'(rand_below(5));
                end else if (k == 2) begin
                    o.inst = inst_ebreak;
                end else begin
                    o.inst = 6'(31 + rand_below(33));
                end
            end
            default: o.inst = 6'(rand_below(64));
        endcase
        w = rand_word();
        if (o.inst == inst_lui || o.inst == inst_auipc) begin
            o.imm = {w[31:12], 12'd0};
        end else begin
            o.imm = {{20{w[11]}}, w[11:0]};
        end
        w      = rand_word();
        o.pc   = {w[31:2], 2'b00};
        o.src1 = rand_word();
        o.src2 = (rand_below(4) == 0) ? o.src1 : rand_word();  // Hit equal operands too.
        return o;
    endfunction

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("[ERROR] %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_result(result_t e);
        check_value("next_pc", e.next_pc, next_pc);
        check_value("rd_wen", {31'd0, e.rd_wen}, {31'd0, rd_wen});
        check_value("halt", {31'd0, e.halt}, {31'd0, halt});
        if (e.check_rd) begin
            check_value("rd_value", e.rd_value, rd_value);
        end
        if (e.inst == inst_jalr) begin
            assert (next_pc[0] == 1'b0) else begin
                $display("jalr target at %0d ns has bit 0 set", $time);
                errors++;
            end
        end
    endtask

    task automatic send_ops(int kind, int count, int max_gap);
        op_t o;
        for (int i = 0; i < count; i++) begin
            o = make_op(kind);
            @(negedge clk);
            inst_num = o.inst;
            imm      = o.imm;
            pc       = o.pc;
            src1     = o.src1;
            src2     = o.src2;
            in_req   = 1'b1;
            do @(negedge clk); while (!in_ack);
            exp_q.push_back(model(o));
            in_req = 1'b0;
            do @(negedge clk); while (in_ack);
            repeat (rand_below(max_gap + 1)) @(negedge clk);
        end
    endtask

    task automatic collect_results(int count, int max_delay);
        result_t e;
        for (int i = 0; i < count; i++) begin
            do @(negedge clk); while (!out_req);
            assert (exp_q.size() > 0) else begin
                $display("out_req rose at %0d ns with no request outstanding", $time);
                errors++;
            end
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                compare_result(e);
            end
            repeat (rand_below(max_delay + 1)) @(negedge clk);
            out_ack = 1'b1;
            do @(negedge clk); while (out_req);
            out_ack = 1'b0;
        end
    endtask

    task automatic report_test(string name, int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
        end
    endtask

    task automatic run_test(string name, int kind, int count, int max_gap, int max_delay);
        int errors_before;
        errors_before = errors;
        fork
            send_ops(kind, count, max_gap);
            collect_results(count, max_delay);
        join
        repeat (4) @(negedge clk);
        assert (!out_req && exp_q.size() == 0) else begin
            $display("%s ended with results left over or an extra out_req", name);
            errors++;
        end
        report_test(name, errors_before);
    endtask

    always @(posedge clk) begin
        req_at_edge <= in_req;
    end

    // in_ack may only rise after an edge that saw in_req high.
    always @(negedge clk) begin
        if (!reset) begin
            assert (!(in_ack && !ack_before && !req_at_edge)) else begin
                $display("in_ack rose at %0d ns while in_req was low", $time);
                errors++;
            end
        end
        ack_before = in_ack;
    end

    initial begin
        repeat (total_ops * 60) @(posedge clk);
        $display("Timeout after %0d cycles, the DUT stopped answering", total_ops * 60);
        $display("Verification failed");
        $finish;
    end

    initial begin
        int errors_before;
        reset    = 1'b1;
        in_req   = 1'b0;
        out_ack  = 1'b0;
        inst_num = '0;
        imm      = '0;
        pc       = '0;
        src1     = '0;
        src2     = '0;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        errors_before = errors;
        repeat (2) @(negedge clk);
        check_value("in_ack", 32'd0, {31'd0, in_ack});
        check_value("out_req", 32'd0, {31'd0, out_req});
        report_test("idle after reset", errors_before);

        run_test("alu ops", 0, n_alu, 2, 2);
        run_test("branches", 1, n_branch, 2, 2);
        run_test("lui auipc jal jalr", 2, n_jump, 2, 2);
        run_test("memory and halt", 3, n_mem, 2, 2);
        run_test("mixed stream", 4, n_mixed, 5, 7);

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
hw/exu_pkg.sv
hw/exu_op_if.sv
hw/exu_in.sv
hw/exu_alu.sv
hw/exu_pc.sv
hw/exu_out.sv
hw/exu_top.sv
testbench/exu_tb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -u

build_dir=build
log=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f files.f \
    --top-module exu_tb \
    -Mdir "$build_dir"
if [ $? -ne 0 ]; then
    echo "Verilator build did not succeed"
    exit 1
fi

"./$build_dir/Vexu_tb" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$log"; then
    exit 1
fi

if ! grep -q "Verification passed" "$log"; then
    echo "No result line found in $log"
    exit 1
fi

exit 0
